// ==== logic/game_consts.svh ====
`ifndef GAME_CONSTS_SVH
`define GAME_CONSTS_SVH

// Field widths
`define COORD_W          9
`define HEALTH_W         7
`define SCORE_W          8
`define DAMAGE_W         10
`define RESPAWN_W        10
`define TICK_CNT_W       2
`define AXIL_ADDR_W      5
`define AXIL_DATA_W      32

// Hit boxes, in pixels
`define ATTACK_SHORT     16
`define ATTACK_LONG      80
`define ENEMY_W          26
`define ENEMY_H          26

`define PLAYER_DAMAGE    25
`define FULL_HEALTH      100
`define ENEMY_DAMAGE     10
`define RESPAWN_TICKS    200
`define TICK_DIV         4

// Register map
`define ADDR_ATTACK_POS  5'h00
`define ADDR_ENEMY_POS   5'h04
`define ADDR_CONTROL     5'h08
`define ADDR_STATUS      5'h10
`define ADDR_DAMAGE      5'h14

`define AXI_RESP_OKAY    2'b00
`define AXI_RESP_SLVERR  2'b10

// Bit positions inside the register words
`define POS_Y_LSB        16
`define CTRL_ATTACK_BIT  4
`define CTRL_STRIKE_BIT  8
`define STAT_ALIVE_BIT   7
`define STAT_SCORE_LSB   8
`define STAT_RESPAWN_LSB 16

`endif

// ==== logic/game_geom_pkg.sv ====
`include "game_consts.svh"

package game_geom_pkg;

    // Screen coordinate, 0 at the top left
    typedef logic [`COORD_W-1:0] coord_t;

    // Facing of the player, sets the attack box shape
    typedef enum logic [1:0] {
        DIR_DOWN  = 2'd0,
        DIR_LEFT  = 2'd1,
        DIR_UP    = 2'd2,
        DIR_RIGHT = 2'd3
    } dir_e;

    typedef struct packed {
        coord_t attack_x;
        coord_t attack_y;
        coord_t enemy_x;
        coord_t enemy_y;
        dir_e   dir;
    } positions_t;

endpackage

// ==== logic/game_state_pkg.sv ====
`include "game_consts.svh"

package game_state_pkg;

    typedef logic [`HEALTH_W-1:0]  health_t;
    typedef logic [`SCORE_W-1:0]   score_t;
    typedef logic [`DAMAGE_W-1:0]  damage_t;
    typedef logic [`RESPAWN_W-1:0] respawn_t;

    typedef enum logic {
        ENEMY_DEAD  = 1'b0,
        ENEMY_ALIVE = 1'b1
    } enemy_state_e;

    typedef struct packed {
        health_t      health;
        enemy_state_e state;
        score_t       score;
        // Total damage dealt to the player
        damage_t      damage;
        // Slow ticks spent dead
        respawn_t     respawn;
    } combat_status_t;

    typedef enum logic [`AXIL_ADDR_W-1:0] {
        REG_ATTACK_POS = `ADDR_ATTACK_POS,
        REG_ENEMY_POS  = `ADDR_ENEMY_POS,
        REG_CONTROL    = `ADDR_CONTROL,
        REG_STATUS     = `ADDR_STATUS,
        REG_DAMAGE     = `ADDR_DAMAGE
    } reg_addr_e;

endpackage

// ==== logic/frame_tick_div.sv ====
`include "game_consts.svh"

module frame_tick_div (
    input  logic Clk,
    input  logic arst_n,
    input  logic frame_strobe,
    output logic slow_tick
);

    logic [1:0]             sync_q;
    logic                   prev_q;
    logic                   rise;
    logic [`TICK_CNT_W-1:0] cnt_q;
    logic                   tick_q;

    assign rise = sync_q[1] & ~prev_q;

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            sync_q <= '0;
            prev_q <= 1'b0;
            cnt_q  <= '0;
            tick_q <= 1'b0;
        end else begin
            sync_q <= {sync_q[0], frame_strobe};
            prev_q <= sync_q[1];
            tick_q <= 1'b0;
            if (rise) begin
                if (cnt_q == `TICK_CNT_W'(`TICK_DIV - 1)) begin
                    cnt_q  <= '0;
                    tick_q <= 1'b1;
                end else begin
                    cnt_q <= cnt_q + 1'b1;
                end
            end
        end
    end

    assign slow_tick = tick_q;

    // Ticks come from separate frame edges
    a_tick_single: assert property (@(posedge Clk) disable iff (!arst_n)
        slow_tick |=> !slow_tick);

endmodule

// ==== logic/attack_hit_detect.sv ====
`include "game_consts.svh"

module attack_hit_detect (
    input  logic                        Clk,
    input  logic                        arst_n,
    input  game_geom_pkg::positions_t   positions,
    input  logic                        strike,
    input  game_state_pkg::enemy_state_e alive,
    output logic                        hit
);
    import game_geom_pkg::*;
    import game_state_pkg::*;

    // Two spare bits so the sums never overflow
    typedef logic [`COORD_W+1:0] ext_t;

    ext_t x_back;
    ext_t x_fwd;
    ext_t y_back;
    ext_t y_fwd;
    logic x_ok;
    logic y_ok;
    logic hit_q;

    // Reach of the attack box around the attack point
    always_comb begin
        x_back = '0;
        x_fwd  = '0;
        y_back = '0;
        y_fwd  = '0;
        case (positions.dir)
            DIR_DOWN: begin
                x_fwd = ext_t'(`ATTACK_SHORT);
                y_fwd = ext_t'(`ATTACK_LONG);
            end
            DIR_LEFT: begin
                x_back = ext_t'(`ATTACK_LONG);
                y_fwd  = ext_t'(`ATTACK_SHORT);
            end
            DIR_UP: begin
                x_fwd  = ext_t'(`ATTACK_SHORT);
                y_back = ext_t'(`ATTACK_LONG);
            end
            DIR_RIGHT: begin
                x_fwd = ext_t'(`ATTACK_LONG);
                y_fwd = ext_t'(`ATTACK_SHORT);
            end
        endcase
    end

    // Inclusive overlap, written without subtraction
    assign x_ok = (ext_t'(positions.enemy_x) + ext_t'(`ENEMY_W) + x_back
                   >= ext_t'(positions.attack_x))
               && (ext_t'(positions.enemy_x) <= ext_t'(positions.attack_x) + x_fwd);
    assign y_ok = (ext_t'(positions.enemy_y) + ext_t'(`ENEMY_H) + y_back
                   >= ext_t'(positions.attack_y))
               && (ext_t'(positions.enemy_y) <= ext_t'(positions.attack_y) + y_fwd);

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            hit_q <= 1'b0;
        end else begin
            hit_q <= strike && (alive == ENEMY_ALIVE) && x_ok && y_ok;
        end
    end

    assign hit = hit_q;

    a_hit_after_strike: assert property (@(posedge Clk) disable iff (!arst_n)
        hit |-> $past(strike));

endmodule

// ==== logic/combat_tracker.sv ====
`include "game_consts.svh"

module combat_tracker (
    input  logic                           Clk,
    input  logic                           arst_n,
    input  logic                           hit,
    input  logic                           slow_tick,
    input  logic                           enemy_attack,
    output game_state_pkg::combat_status_t status
);
    import game_state_pkg::*;

    enemy_state_e state_q;
    enemy_state_e state_d;
    health_t      health_q;
    health_t      health_d;
    score_t       score_q;
    score_t       score_d;
    respawn_t     respawn_q;
    respawn_t     respawn_d;
    damage_t      damage_q;

    always_comb begin
        state_d   = state_q;
        health_d  = health_q;
        score_d   = score_q;
        respawn_d = respawn_q;
        case (state_q)
            ENEMY_ALIVE: begin
                if (hit) begin
                    score_d = score_q + 1'b1;
                    // Clamp at zero, the last hit kills
                    if (health_q > health_t'(`PLAYER_DAMAGE)) begin
                        health_d = health_q - health_t'(`PLAYER_DAMAGE);
                    end else begin
                        health_d = '0;
                        state_d  = ENEMY_DEAD;
                    end
                end
            end
            ENEMY_DEAD: begin
                if (slow_tick) begin
                    if (respawn_q == respawn_t'(`RESPAWN_TICKS)) begin
                        respawn_d = '0;
                        health_d  = health_t'(`FULL_HEALTH);
                        state_d   = ENEMY_ALIVE;
                    end else begin
                        respawn_d = respawn_q + 1'b1;
                    end
                end
            end
        endcase
    end

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q   <= ENEMY_ALIVE;
            health_q  <= health_t'(`FULL_HEALTH);
            score_q   <= '0;
            respawn_q <= '0;
            damage_q  <= '0;
        end else begin
            state_q   <= state_d;
            health_q  <= health_d;
            score_q   <= score_d;
            respawn_q <= respawn_d;
            // Enemy hurts the player once per slow tick
            if (slow_tick && enemy_attack) begin
                damage_q <= damage_q + damage_t'(`ENEMY_DAMAGE);
            end
        end
    end

    assign status = '{health:  health_q,
                      state:   state_q,
                      score:   score_q,
                      damage:  damage_q,
                      respawn: respawn_q};

    a_dead_at_zero: assert property (@(posedge Clk) disable iff (!arst_n)
        (health_q == '0) == (state_q == ENEMY_DEAD));

endmodule

// ==== logic/game_axil_regs.sv ====
`include "game_consts.svh"

module game_axil_regs (
    input  logic                           Clk,
    input  logic                           arst_n,
    input  logic [`AXIL_ADDR_W-1:0]        awaddr,
    input  logic                           awvalid,
    output logic                           awready,
    input  logic [`AXIL_DATA_W-1:0]        wdata,
    input  logic [`AXIL_DATA_W/8-1:0]      wstrb,
    input  logic                           wvalid,
    output logic                           wready,
    output logic [1:0]                     bresp,
    output logic                           bvalid,
    input  logic                           bready,
    input  logic [`AXIL_ADDR_W-1:0]        araddr,
    input  logic                           arvalid,
    output logic                           arready,
    output logic [`AXIL_DATA_W-1:0]        rdata,
    output logic [1:0]                     rresp,
    output logic                           rvalid,
    input  logic                           rready,
    output game_geom_pkg::positions_t      positions,
    output logic                           enemy_attack,
    output logic                           strike,
    input  game_state_pkg::combat_status_t status
);
    import game_geom_pkg::*;
    import game_state_pkg::*;

    typedef logic [`AXIL_DATA_W-1:0] word_t;

    logic       wr_en;
    logic       rd_en;
    reg_addr_e  wr_addr;
    reg_addr_e  rd_addr;
    word_t      attack_word;
    word_t      enemy_word;
    word_t      ctrl_word;
    word_t      status_word;
    word_t      damage_word;
    word_t      wr_old;
    word_t      wr_new;
    word_t      rd_word;
    logic [1:0] wr_resp;
    logic [1:0] rd_resp;
    positions_t pos_q;
    logic       enemy_attack_q;
    logic       strike_q;
    logic       bvalid_q;
    logic       rvalid_q;
    logic [1:0] bresp_q;
    logic [1:0] rresp_q;
    word_t      rdata_q;

    function automatic word_t pack_xy(input coord_t x, input coord_t y);
        word_t w;
        w = '0;
        w[`COORD_W-1:0] = x;
        w[`POS_Y_LSB +: `COORD_W] = y;
        return w;
    endfunction

    function automatic word_t merge_strb(input word_t old_w, input word_t new_w,
                                         input logic [`AXIL_DATA_W/8-1:0] strb);
        word_t w;
        w = old_w;
        for (int i = 0; i < `AXIL_DATA_W/8; i++) begin
            if (strb[i]) begin
                w[8*i +: 8] = new_w[8*i +: 8];
            end
        end
        return w;
    endfunction

    // Address and data beats are taken together
    assign wr_en   = awvalid && wvalid && !bvalid_q;
    assign rd_en   = arvalid && !rvalid_q;
    assign wr_addr = reg_addr_e'(awaddr);
    assign rd_addr = reg_addr_e'(araddr);

    always_comb begin
        attack_word = pack_xy(pos_q.attack_x, pos_q.attack_y);
        enemy_word  = pack_xy(pos_q.enemy_x, pos_q.enemy_y);
        ctrl_word   = '0;
        ctrl_word[$bits(dir_e)-1:0]  = pos_q.dir;
        ctrl_word[`CTRL_ATTACK_BIT]  = enemy_attack_q;
        status_word = '0;
        status_word[`HEALTH_W-1:0]   = status.health;
        status_word[`STAT_ALIVE_BIT] = (status.state == ENEMY_ALIVE);
        status_word[`STAT_SCORE_LSB +: `SCORE_W]     = status.score;
        status_word[`STAT_RESPAWN_LSB +: `RESPAWN_W] = status.respawn;
        damage_word = '0;
        damage_word[`DAMAGE_W-1:0]   = status.damage;
    end

    // Current word of the write target, for the byte merge
    always_comb begin
        wr_old  = '0;
        wr_resp = `AXI_RESP_OKAY;
        case (wr_addr)
            REG_ATTACK_POS: wr_old = attack_word;
            REG_ENEMY_POS:  wr_old = enemy_word;
            REG_CONTROL:    wr_old = ctrl_word;
            REG_STATUS, REG_DAMAGE: wr_old = '0;
            default:        wr_resp = `AXI_RESP_SLVERR;
        endcase
    end

    assign wr_new = merge_strb(wr_old, wdata, wstrb);

    always_comb begin
        rd_word = '0;
        rd_resp = `AXI_RESP_OKAY;
        case (rd_addr)
            REG_ATTACK_POS: rd_word = attack_word;
            REG_ENEMY_POS:  rd_word = enemy_word;
            REG_CONTROL:    rd_word = ctrl_word;
            REG_STATUS:     rd_word = status_word;
            REG_DAMAGE:     rd_word = damage_word;
            default:        rd_resp = `AXI_RESP_SLVERR;
        endcase
    end

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            pos_q          <= '0;
            enemy_attack_q <= 1'b0;
            strike_q       <= 1'b0;
            bvalid_q       <= 1'b0;
            rvalid_q       <= 1'b0;
        end else begin
            strike_q <= 1'b0;
            if (wr_en) begin
                bvalid_q <= 1'b1;
                case (wr_addr)
                    REG_ATTACK_POS: begin
                        pos_q.attack_x <= wr_new[`COORD_W-1:0];
                        pos_q.attack_y <= wr_new[`POS_Y_LSB +: `COORD_W];
                    end
                    REG_ENEMY_POS: begin
                        pos_q.enemy_x <= wr_new[`COORD_W-1:0];
                        pos_q.enemy_y <= wr_new[`POS_Y_LSB +: `COORD_W];
                    end
                    REG_CONTROL: begin
                        pos_q.dir      <= dir_e'(wr_new[$bits(dir_e)-1:0]);
                        enemy_attack_q <= wr_new[`CTRL_ATTACK_BIT];
                        // Strike is a single cycle command
                        strike_q       <= wr_new[`CTRL_STRIKE_BIT];
                    end
                    default: ;
                endcase
            end else if (bvalid_q && bready) begin
                bvalid_q <= 1'b0;
            end
            if (rd_en) begin
                rvalid_q <= 1'b1;
            end else if (rvalid_q && rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (wr_en) begin
            bresp_q <= wr_resp;
        end
        if (rd_en) begin
            rdata_q <= rd_word;
            rresp_q <= rd_resp;
        end
    end

    assign awready      = wr_en;
    assign wready       = wr_en;
    assign bvalid       = bvalid_q;
    assign bresp        = bresp_q;
    assign arready      = rd_en;
    assign rvalid       = rvalid_q;
    assign rdata        = rdata_q;
    assign rresp        = rresp_q;
    assign positions    = pos_q;
    assign enemy_attack = enemy_attack_q;
    assign strike       = strike_q;

    a_bvalid_hold: assert property (@(posedge Clk) disable iff (!arst_n)
        bvalid && !bready |=> bvalid);

endmodule

// ==== logic/game_logic_top.sv ====
`include "game_consts.svh"

module game_logic_top (
    input  logic                      Clk,
    input  logic                      arst_n,
    input  logic                      frame_strobe,
    input  logic [`AXIL_ADDR_W-1:0]   awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [`AXIL_DATA_W-1:0]   wdata,
    input  logic [`AXIL_DATA_W/8-1:0] wstrb,
    input  logic                      wvalid,
    output logic                      wready,
    output logic [1:0]                bresp,
    output logic                      bvalid,
    input  logic                      bready,
    input  logic [`AXIL_ADDR_W-1:0]   araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output logic [`AXIL_DATA_W-1:0]   rdata,
    output logic [1:0]                rresp,
    output logic                      rvalid,
    input  logic                      rready
);
    import game_geom_pkg::*;
    import game_state_pkg::*;

    positions_t     positions;
    combat_status_t status;
    logic           enemy_attack;
    logic           strike;
    logic           slow_tick;
    logic           hit;

    game_axil_regs i_regs (
        .Clk          (Clk),
        .arst_n       (arst_n),
        .awaddr       (awaddr),
        .awvalid      (awvalid),
        .awready      (awready),
        .wdata        (wdata),
        .wstrb        (wstrb),
        .wvalid       (wvalid),
        .wready       (wready),
        .bresp        (bresp),
        .bvalid       (bvalid),
        .bready       (bready),
        .araddr       (araddr),
        .arvalid      (arvalid),
        .arready      (arready),
        .rdata        (rdata),
        .rresp        (rresp),
        .rvalid       (rvalid),
        .rready       (rready),
        .positions    (positions),
        .enemy_attack (enemy_attack),
        .strike       (strike),
        .status       (status)
    );

    frame_tick_div i_tick_div (
        .Clk          (Clk),
        .arst_n       (arst_n),
        .frame_strobe (frame_strobe),
        .slow_tick    (slow_tick)
    );

    attack_hit_detect i_hit_detect (
        .Clk       (Clk),
        .arst_n    (arst_n),
        .positions (positions),
        .strike    (strike),
        .alive     (status.state),
        .hit       (hit)
    );

    combat_tracker i_tracker (
        .Clk          (Clk),
        .arst_n       (arst_n),
        .hit          (hit),
        .slow_tick    (slow_tick),
        .enemy_attack (enemy_attack),
        .status       (status)
    );

endmodule

// ==== dv/game_logic_tb.sv ====
`include "game_consts.svh"

module game_logic_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int AXI_TIMEOUT = 50;
    localparam int HIT_LATENCY = 3;
    localparam int MAX_DELAY   = 4;

    logic                      Clk = 1'b0;
    logic                      arst_n;
    logic                      frame_strobe;
    logic [`AXIL_ADDR_W-1:0]   awaddr;
    logic                      awvalid;
    logic                      awready;
    logic [`AXIL_DATA_W-1:0]   wdata;
    logic [`AXIL_DATA_W/8-1:0] wstrb;
    logic                      wvalid;
    logic                      wready;
    logic [1:0]                bresp;
    logic                      bvalid;
    logic                      bready;
    logic [`AXIL_ADDR_W-1:0]   araddr;
    logic                      arvalid;
    logic                      arready;
    logic [`AXIL_DATA_W-1:0]   rdata;
    logic [1:0]                rresp;
    logic                      rvalid;
    logic                      rready;

    integer seed         = 32'h89c;
    int     err_count    = 0;
    int     test_errors  = 0;
    int     tests_passed = 0;
    int     tests_failed = 0;
    logic   timed_out    = 1'b0;

    game_logic_top i_dut (.*);

    always #2 Clk = ~Clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("Fail at %0.1f ns: %s got 0x%08h, expected 0x%08h",
                     $realtime, name, got, expected);
            err_count++;
            test_errors++;
        end
    endtask

    task automatic note_timeout(input string what);
        $display("Timeout: %s did not arrive within %0d cycles", what, AXI_TIMEOUT);
        err_count++;
        test_errors++;
        timed_out = 1'b1;
    endtask

    // Each call starts and ends just after a rising edge
    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge Clk);
            #0.5;
        end
    endtask

    function automatic int random_delay();
        return $unsigned($random(seed)) % MAX_DELAY;
    endfunction

    task automatic axil_write(input logic [4:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        int cycles;
        resp    = 2'b00;
        awaddr  = addr;
        wdata   = data;
        wstrb   = '1;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        cycles  = 0;
        @(negedge Clk);
        while (!(awready && wready) && cycles < AXI_TIMEOUT) begin
            cycles++;
            @(negedge Clk);
        end
        if (!(awready && wready)) begin
            note_timeout("awready and wready");
        end
        @(posedge Clk);
        #0.5;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        if (timed_out) begin
            return;
        end
        idle_cycles(random_delay());
        bready = 1'b1;
        cycles = 0;
        @(negedge Clk);
        while (!bvalid && cycles < AXI_TIMEOUT) begin
            cycles++;
            @(negedge Clk);
        end
        if (!bvalid) begin
            note_timeout("bvalid");
        end
        resp = bresp;
        @(posedge Clk);
        #0.5;
        bready = 1'b0;
        // Strike to visible status takes three cycles after B
        idle_cycles(HIT_LATENCY);
    endtask

    task automatic axil_read(input logic [4:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        int cycles;
        data    = '0;
        resp    = 2'b00;
        araddr  = addr;
        arvalid = 1'b1;
        cycles  = 0;
        @(negedge Clk);
        while (!arready && cycles < AXI_TIMEOUT) begin
            cycles++;
            @(negedge Clk);
        end
        if (!arready) begin
            note_timeout("arready");
        end
        @(posedge Clk);
        #0.5;
        arvalid = 1'b0;
        if (timed_out) begin
            return;
        end
        idle_cycles(random_delay());
        rready = 1'b1;
        cycles = 0;
        @(negedge Clk);
        while (!rvalid && cycles < AXI_TIMEOUT) begin
            cycles++;
            @(negedge Clk);
        end
        if (!rvalid) begin
            note_timeout("rvalid");
        end
        data = rdata;
        resp = rresp;
        @(posedge Clk);
        #0.5;
        rready = 1'b0;
    endtask

    // Three cycles high, three low, so the synchronizer sees every edge
    task automatic frame_pulses(input int n);
        repeat (n) begin
            frame_strobe = 1'b1;
            idle_cycles(3);
            frame_strobe = 1'b0;
            idle_cycles(3);
        end
    endtask

    task automatic close_test(input string name);
        if (test_errors == 0) begin
            $display("Test %s passed", name);
            tests_passed++;
        end else begin
            $display("Test %s failed with %0d errors", name, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    initial begin
        int          fd;
        int          code;
        int          count;
        logic        done;
        logic [7:0]  op;
        string       name;
        string       line;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] exp_resp;
        logic [31:0] rd_data;
        logic [1:0]  resp;
        arst_n       = 1'b0;
        frame_strobe = 1'b0;
        awaddr       = '0;
        awvalid      = 1'b0;
        wdata        = '0;
        wstrb        = '0;
        wvalid       = 1'b0;
        bready       = 1'b0;
        araddr       = '0;
        arvalid      = 1'b0;
        rready       = 1'b0;
        repeat (3) @(posedge Clk);
        #0.5;
        arst_n = 1'b1;
        idle_cycles(1);

        done = 1'b0;
        fd   = $fopen("dv/game_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file dv/game_cases.txt");
            err_count++;
            done = 1'b1;
        end
        while (!done) begin
            code = $fscanf(fd, " %c", op);
            if (code != 1) begin
                done = 1'b1;
            end else begin
                case (op)
                    "#": code = $fgets(line, fd);
                    "W": begin
                        code = $fscanf(fd, "%h %h %h", addr, data, exp_resp);
                        axil_write(addr[4:0], data, resp);
                        if (!timed_out) begin
                            check_value($sformatf("bresp[%02h]", addr[4:0]), 32'(resp),
                                        exp_resp);
                        end
                    end
                    "R": begin
                        code = $fscanf(fd, "%h %h %h", addr, data, exp_resp);
                        axil_read(addr[4:0], rd_data, resp);
                        if (!timed_out) begin
                            check_value($sformatf("rresp[%02h]", addr[4:0]), 32'(resp),
                                        exp_resp);
                            // Data of an error response is not defined
                            if (exp_resp == 32'h0) begin
                                check_value($sformatf("rdata[%02h]", addr[4:0]), rd_data,
                                            data);
                            end
                        end
                    end
                    "F": begin
                        code = $fscanf(fd, "%d", count);
                        frame_pulses(count);
                    end
                    "T": begin
                        code = $fscanf(fd, "%s", name);
                        close_test(name);
                    end
                    default: begin
                        $display("Unknown opcode %c in the case file", op);
                        err_count++;
                        done = 1'b1;
                    end
                endcase
                if (timed_out) begin
                    done = 1'b1;
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        if (tests_passed + tests_failed == 0) begin
            $display("No test was completed from the case file");
            err_count++;
        end

        $display("Tests: %0d passed, %0d failed, %0d errors",
                 tests_passed, tests_failed, err_count);
        if (err_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== dv/game_cases.txt ====
# W addr data resp | R addr expected_data expected_resp | F pulse_count | T test_name
# Hex addr, data and resp; decimal pulse count; read data is skipped when resp is 2
R 10 000000E4 0
R 14 00000000 0
T reset_values
W 00 00C800C8 0
R 00 00C800C8 0
W 04 011900D2 0
W 08 00000100 0
R 10 000000E4 0
W 04 00FA00D2 0
W 08 00000100 0
R 10 000001CB 0
T strike_down
W 04 00CD005D 0
W 08 00000101 0
R 10 000001CB 0
W 04 00CD0064 0
W 08 00000101 0
R 10 000002B2 0
T strike_left
W 04 005D00CD 0
W 08 00000102 0
R 10 000002B2 0
W 04 006400CD 0
W 08 00000102 0
R 10 00000399 0
T strike_up
W 04 00CD0119 0
W 08 00000103 0
R 10 00000399 0
W 04 00CD010E 0
W 08 00000103 0
R 10 00000400 0
T strike_right_kill
W 08 00000103 0
R 10 00000400 0
T strike_when_dead
F 400
R 10 00640400 0
F 404
R 10 000004E4 0
T respawn
W 08 00000010 0
R 08 00000010 0
F 8
R 14 00000014 0
W 08 00000000 0
F 8
R 14 00000014 0
T player_damage
R 0C 00000000 2
W 18 12345678 2
R 10 000004E4 0
T unmapped_slverr

// ==== all.f ====
+incdir+logic
logic/game_geom_pkg.sv
logic/game_state_pkg.sv
logic/frame_tick_div.sv
logic/attack_hit_detect.sv
logic/combat_tracker.sv
logic/game_axil_regs.sv
logic/game_logic_top.sv
dv/game_logic_tb.sv

// ==== Bender.yml ====
package:
  name: game_logic

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/game_geom_pkg.sv
      - logic/game_state_pkg.sv
      - logic/frame_tick_div.sv
      - logic/attack_hit_detect.sv
      - logic/combat_tracker.sv
      - logic/game_axil_regs.sv
      - logic/game_logic_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - dv/game_logic_tb.sv
